/* src/axis_pkg.sv */
// Byte-wide stream beat type shared by the receive and transmit frame paths
`default_nettype none

package axis_pkg;

    // Width of the data byte carried in one beat
    localparam int AXIS_DATA_W = 8;

    // One stream beat
    // bad only has meaning when last is set
    typedef struct packed {
        logic [AXIS_DATA_W-1:0] data;
        logic                   last;
        logic                   bad;
    } axis_beat_t;

endpackage

`default_nettype wire

/* src/stat_pkg.sv */
// Statistics increment type, statistic kinds and index and length widths
`default_nettype none

package stat_pkg;

    // Width of a statistic index
    localparam int STAT_ID_W = 8;

    // Width of a frame length field, wraps on long frames
    localparam int STAT_LEN_W = 16;

    // Frame outcomes counted per channel
    typedef enum logic [1:0] {
        STAT_GOOD     = 2'd0,
        STAT_BAD      = 2'd1,
        STAT_OVERFLOW = 2'd2
    } stat_kind_e;

    // Number of kinds per channel
    // channel n owns indices n*STAT_KINDS up to n*STAT_KINDS+STAT_KINDS-1
    localparam int STAT_KINDS = 3;

    // One statistics increment
    typedef struct packed {
        logic [STAT_ID_W-1:0]  id;
        logic [STAT_LEN_W-1:0] len;
    } stat_inc_t;

endpackage

`default_nettype wire

/* src/frame_fifo.sv */
// Store-and-forward frame FIFO with bad and overflow frame drop and per-frame increments
`timescale 1ns/1ps
`default_nettype none

module frame_fifo #(
    parameter int FIFO_DEPTH   = 64,
    parameter int STAT_ID_BASE = 0
) (
    input  wire logic                 clk_125mhz,
    input  wire logic                 arst_n,

    // Receive stream
    input  wire axis_pkg::axis_beat_t rx_beat,
    input  wire logic                 rx_valid,
    output logic                      rx_ready,

    // Transmit stream
    output axis_pkg::axis_beat_t      tx_beat,
    output logic                      tx_valid,
    input  wire logic                 tx_ready,

    // Statistics increment output
    output stat_pkg::stat_inc_t       stat_inc,
    output logic                      stat_valid,
    input  wire logic                 stat_ready
);

    localparam int ADDR_W = $clog2(FIFO_DEPTH);
    localparam int PTR_W  = ADDR_W + 1;
    localparam int ID_W   = stat_pkg::STAT_ID_W;
    localparam int LEN_W  = stat_pkg::STAT_LEN_W;

    // Byte RAM holding data and last flag
    logic [8:0]             mem [FIFO_DEPTH];
    logic [8:0]             rd_word;

    // Pointers carry one extra bit to tell full from empty
    logic [PTR_W-1:0]       wr_ptr;
    logic [PTR_W-1:0]       commit_ptr;
    logic [PTR_W-1:0]       rd_ptr;

    // Bytes of the current frame seen so far
    logic [LEN_W-1:0]       frame_len;

    logic                   frame_full;
    logic                   fifo_full;
    logic                   rx_xfer;
    logic                   wr_en;
    logic                   tx_xfer;
    stat_pkg::stat_kind_e   frame_kind;

    // Current frame alone fills the buffer, so it can never fit
    assign frame_full = (wr_ptr - commit_ptr) == PTR_W'(FIFO_DEPTH);

    // Buffer full because committed frames still wait for transmit
    assign fifo_full = (wr_ptr - rd_ptr) == PTR_W'(FIFO_DEPTH);

    // Hold the last beat while the previous increment is still pending
    // An oversize frame keeps ready high and is discarded
    assign rx_ready = !(rx_beat.last && stat_valid) && (frame_full || !fifo_full);

    assign rx_xfer = rx_valid && rx_ready;
    assign wr_en   = rx_xfer && !frame_full;

    // Outcome of the frame ending on the current beat
    always_comb begin
        if (frame_full) begin
            frame_kind = stat_pkg::STAT_OVERFLOW;
        end else if (rx_beat.bad) begin
            frame_kind = stat_pkg::STAT_BAD;
        end else begin
            frame_kind = stat_pkg::STAT_GOOD;
        end
    end

    always_ff @(posedge clk_125mhz) begin
        if (wr_en) begin
            mem[wr_ptr[ADDR_W-1:0]] <= {rx_beat.last, rx_beat.data};
        end
    end

    // Only committed bytes are visible on the transmit side
    assign rd_word  = mem[rd_ptr[ADDR_W-1:0]];
    assign tx_valid = rd_ptr != commit_ptr;
    assign tx_xfer  = tx_valid && tx_ready;
    assign tx_beat  = '{data: rd_word[7:0], last: rd_word[8], bad: 1'b0};

    always_ff @(posedge clk_125mhz or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr     <= '0;
            commit_ptr <= '0;
            rd_ptr     <= '0;
            frame_len  <= '0;
            stat_valid <= 1'b0;
        end else begin
            if (tx_xfer) begin
                rd_ptr <= rd_ptr + 1'b1;
            end

            if (stat_valid && stat_ready) begin
                stat_valid <= 1'b0;
            end

            if (rx_xfer) begin
                if (rx_beat.last) begin
                    frame_len  <= '0;
                    stat_valid <= 1'b1;
                    if (frame_kind == stat_pkg::STAT_GOOD) begin
                        wr_ptr     <= wr_ptr + 1'b1;
                        commit_ptr <= wr_ptr + 1'b1;
                    end else begin
                        // Rewind over the dropped frame
                        wr_ptr <= commit_ptr;
                    end
                end else begin
                    frame_len <= frame_len + 1'b1;
                    if (!frame_full) begin
                        wr_ptr <= wr_ptr + 1'b1;
                    end
                end
            end
        end
    end

    // Increment payload, loaded once per frame on its last beat
    always_ff @(posedge clk_125mhz) begin
        if (rx_xfer && rx_beat.last) begin
            stat_inc.id  <= ID_W'(STAT_ID_BASE) + ID_W'(frame_kind);
            stat_inc.len <= frame_len + 1'b1;
        end
    end

    // Pending increment stays put until the arbiter takes it
    stat_hold_a : assert property (
        @(posedge clk_125mhz) disable iff (!arst_n)
        stat_valid && !stat_ready |=> stat_valid && $stable(stat_inc)
    );

    // Transmit never reads past committed data
    rd_commit_a : assert property (
        @(posedge clk_125mhz) disable iff (!arst_n)
        PTR_W'(commit_ptr - rd_ptr) <= PTR_W'(FIFO_DEPTH)
    );

endmodule

`default_nettype wire

/* src/stat_arb_mux.sv */
// Round-robin merge of per-channel statistics increment streams
`timescale 1ns/1ps
`default_nettype none

module stat_arb_mux #(
    parameter int CH_COUNT = 2
) (
    input  wire logic                clk_125mhz,
    input  wire logic                arst_n,

    // Per-channel increment inputs
    input  wire stat_pkg::stat_inc_t in_inc [CH_COUNT],
    input  wire logic [CH_COUNT-1:0] in_valid,
    output logic [CH_COUNT-1:0]      in_ready,

    // Merged increment output
    output stat_pkg::stat_inc_t      out_inc,
    output logic                     out_valid
);

    localparam int SEL_W = (CH_COUNT > 1) ? $clog2(CH_COUNT) : 1;

    logic [SEL_W-1:0] last_sel;
    logic [SEL_W-1:0] grant_sel;
    logic             grant_any;

    // Search starts at the channel after the last winner
    always_comb begin
        int idx;
        grant_any = 1'b0;
        grant_sel = last_sel;
        in_ready  = '0;
        for (int i = 1; i <= CH_COUNT; i++) begin
            idx = (int'(last_sel) + i) % CH_COUNT;
            if (!grant_any && in_valid[idx]) begin
                grant_any = 1'b1;
                grant_sel = SEL_W'(idx);
            end
        end
        if (grant_any) begin
            in_ready[grant_sel] = 1'b1;
        end
    end

    always_ff @(posedge clk_125mhz or negedge arst_n) begin
        if (!arst_n) begin
            // Channel 0 wins first
            last_sel  <= SEL_W'(CH_COUNT - 1);
            out_valid <= 1'b0;
        end else begin
            out_valid <= grant_any;
            if (grant_any) begin
                last_sel <= grant_sel;
            end
        end
    end

    always_ff @(posedge clk_125mhz) begin
        if (grant_any) begin
            out_inc <= in_inc[grant_sel];
        end
    end

    // One grant per cycle
    // Last winner waits while any other channel requests
    one_grant_a : assert property (
        @(posedge clk_125mhz) disable iff (!arst_n)
        $onehot0(in_ready) && !(in_ready[last_sel] && $countones(in_valid) > 1)
    );

endmodule

`default_nettype wire

/* src/stat_counter.sv */
// Frame and byte counter bank updated by increments with a strobed read port
`timescale 1ns/1ps
`default_nettype none

module stat_counter #(
    parameter int CH_COUNT     = 2,
    parameter int STAT_COUNT_W = 32
) (
    input  wire logic                          clk_125mhz,
    input  wire logic                          arst_n,

    // Increment input, always accepted
    input  wire stat_pkg::stat_inc_t           inc,
    input  wire logic                          inc_valid,

    // Read port
    input  wire logic                          rd_en,
    input  wire logic [stat_pkg::STAT_ID_W-1:0] rd_addr,
    output logic                               rd_valid,
    output logic [STAT_COUNT_W-1:0]            rd_frames,
    output logic [STAT_COUNT_W-1:0]            rd_bytes
);

    localparam int N     = CH_COUNT * stat_pkg::STAT_KINDS;
    localparam int IDX_W = (N > 1) ? $clog2(N) : 1;
    localparam int ID_W  = stat_pkg::STAT_ID_W;

    logic [STAT_COUNT_W-1:0] frame_cnt [N];
    logic [STAT_COUNT_W-1:0] byte_cnt  [N];

    logic             inc_hit;
    logic             rd_hit;
    logic [IDX_W-1:0] inc_idx;
    logic [IDX_W-1:0] rd_idx;

    assign inc_hit = inc_valid && (inc.id < ID_W'(N));
    assign rd_hit  = rd_addr < ID_W'(N);
    assign inc_idx = inc.id[IDX_W-1:0];
    assign rd_idx  = rd_addr[IDX_W-1:0];

    always_ff @(posedge clk_125mhz or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < N; i++) begin
                frame_cnt[i] <= '0;
                byte_cnt[i]  <= '0;
            end
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= rd_en;
            if (inc_hit) begin
                frame_cnt[inc_idx] <= frame_cnt[inc_idx] + 1'b1;
                byte_cnt[inc_idx]  <= byte_cnt[inc_idx] + STAT_COUNT_W'(inc.len);
            end
        end
    end

    // Read data, zero for an unmapped index
    always_ff @(posedge clk_125mhz) begin
        if (rd_en) begin
            if (rd_hit) begin
                rd_frames <= frame_cnt[rd_idx];
                rd_bytes  <= byte_cnt[rd_idx];
            end else begin
                rd_frames <= '0;
                rd_bytes  <= '0;
            end
        end
    end

    // Channel bases upstream must stay inside the bank
    inc_range_a : assert property (
        @(posedge clk_125mhz) disable iff (!arst_n)
        inc_valid |-> inc.id < ID_W'(N)
    );

endmodule

`default_nettype wire

/* src/fpga_core.sv */
// Top level with per-channel frame FIFOs, increment arbiter and counter bank
`timescale 1ns/1ps
`default_nettype none

module fpga_core #(
    parameter int CH_COUNT     = 2,
    parameter int FIFO_DEPTH   = 64,
    parameter int STAT_COUNT_W = 32
) (
    input  wire logic                           clk_125mhz,
    input  wire logic                           arst_n,

    // Receive streams
    input  wire axis_pkg::axis_beat_t           rx_beat [CH_COUNT],
    input  wire logic [CH_COUNT-1:0]            rx_valid,
    output wire logic [CH_COUNT-1:0]            rx_ready,

    // Transmit streams
    output wire axis_pkg::axis_beat_t           tx_beat [CH_COUNT],
    output wire logic [CH_COUNT-1:0]            tx_valid,
    input  wire logic [CH_COUNT-1:0]            tx_ready,

    // Statistics read port
    input  wire logic                           stat_rd_en,
    input  wire logic [stat_pkg::STAT_ID_W-1:0] stat_rd_addr,
    output wire logic                           stat_rd_valid,
    output wire logic [STAT_COUNT_W-1:0]        stat_rd_frames,
    output wire logic [STAT_COUNT_W-1:0]        stat_rd_bytes
);

    // Per-channel increments into the arbiter
    wire stat_pkg::stat_inc_t  ch_inc [CH_COUNT];
    wire logic [CH_COUNT-1:0]  ch_inc_valid;
    wire logic [CH_COUNT-1:0]  ch_inc_ready;

    // Merged increments into the counter bank
    wire stat_pkg::stat_inc_t  merged_inc;
    wire logic                 merged_valid;

    for (genvar n = 0; n < CH_COUNT; n++) begin : ch

        frame_fifo #(
            .FIFO_DEPTH(FIFO_DEPTH),
            .STAT_ID_BASE(n * stat_pkg::STAT_KINDS)
        ) ch_fifo (
            .clk_125mhz(clk_125mhz),
            .arst_n(arst_n),
            .rx_beat(rx_beat[n]),
            .rx_valid(rx_valid[n]),
            .rx_ready(rx_ready[n]),
            .tx_beat(tx_beat[n]),
            .tx_valid(tx_valid[n]),
            .tx_ready(tx_ready[n]),
            .stat_inc(ch_inc[n]),
            .stat_valid(ch_inc_valid[n]),
            .stat_ready(ch_inc_ready[n])
        );

    end

    stat_arb_mux #(
        .CH_COUNT(CH_COUNT)
    ) stat_mux_inst (
        .clk_125mhz(clk_125mhz),
        .arst_n(arst_n),
        .in_inc(ch_inc),
        .in_valid(ch_inc_valid),
        .in_ready(ch_inc_ready),
        .out_inc(merged_inc),
        .out_valid(merged_valid)
    );

    stat_counter #(
        .CH_COUNT(CH_COUNT),
        .STAT_COUNT_W(STAT_COUNT_W)
    ) stat_counter_inst (
        .clk_125mhz(clk_125mhz),
        .arst_n(arst_n),
        .inc(merged_inc),
        .inc_valid(merged_valid),
        .rd_en(stat_rd_en),
        .rd_addr(stat_rd_addr),
        .rd_valid(stat_rd_valid),
        .rd_frames(stat_rd_frames),
        .rd_bytes(stat_rd_bytes)
    );

endmodule

`default_nettype wire

/* verif/tb_clk_gen.sv */
// Free-running clock source for the testbench
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
    parameter int PERIOD_NS = 100
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2) clk = ~clk;
        end
    end

endmodule

`default_nettype wire

/* verif/fpga_core_tb.sv */
// Testbench for the frame loopback core: file-driven frames, output and counter checks
`timescale 1ns/1ps
`default_nettype none

module fpga_core_tb #(
    parameter int SEED = 76
);

    localparam int    CH_COUNT     = 2;
    localparam int    FIFO_DEPTH   = 64;
    localparam int    STAT_COUNT_W = 32;
    localparam int    N_STATS      = CH_COUNT * stat_pkg::STAT_KINDS;
    localparam int    ALIAS_IDX    = 1 << $clog2(N_STATS);
    localparam int    MAX_TESTS    = 64;
    localparam string INPUT_FILE   = "verif/fpga_core_input.txt";

    logic                              clk;
    logic                              arst_n;
    axis_pkg::axis_beat_t              rx_beat [CH_COUNT];
    logic [CH_COUNT-1:0]               rx_valid;
    wire logic [CH_COUNT-1:0]          rx_ready;
    wire axis_pkg::axis_beat_t         tx_beat [CH_COUNT];
    wire logic [CH_COUNT-1:0]          tx_valid;
    logic [CH_COUNT-1:0]               tx_ready;
    logic                              stat_rd_en;
    logic [stat_pkg::STAT_ID_W-1:0]    stat_rd_addr;
    wire logic                         stat_rd_valid;
    wire logic [STAT_COUNT_W-1:0]      stat_rd_frames;
    wire logic [STAT_COUNT_W-1:0]      stat_rd_bytes;

    // Frame descriptors, indexed in file order
    int t_num [MAX_TESTS];
    int t_len [MAX_TESTS];
    int t_bad [MAX_TESTS];
    int t_start [MAX_TESTS];
    int test_err [MAX_TESTS];
    int n_tests;

    // Per-channel progress of the receive side and the output check
    int ch_list [CH_COUNT][$];
    int good_q [CH_COUNT][$];
    int cur_pos [CH_COUNT];
    int beat_k [CH_COUNT];
    int out_k [CH_COUNT];
    bit started [CH_COUNT];
    bit accepted [CH_COUNT];

    logic [STAT_COUNT_W-1:0] exp_frames [N_STATS];
    logic [STAT_COUNT_W-1:0] exp_bytes [N_STATS];

    int seed;
    int errors;
    int checked;
    int dropped;
    int limit_cycles;
    bit loaded;

    tb_clk_gen #(.PERIOD_NS(100)) clk_gen_i (.clk(clk));

    fpga_core #(
        .CH_COUNT(CH_COUNT),
        .FIFO_DEPTH(FIFO_DEPTH),
        .STAT_COUNT_W(STAT_COUNT_W)
    ) dut_i (
        .clk_125mhz(clk),
        .arst_n(arst_n),
        .rx_beat(rx_beat),
        .rx_valid(rx_valid),
        .rx_ready(rx_ready),
        .tx_beat(tx_beat),
        .tx_valid(tx_valid),
        .tx_ready(tx_ready),
        .stat_rd_en(stat_rd_en),
        .stat_rd_addr(stat_rd_addr),
        .stat_rd_valid(stat_rd_valid),
        .stat_rd_frames(stat_rd_frames),
        .stat_rd_bytes(stat_rd_bytes)
    );

    // Oversize beats bad, bad beats good
    function automatic int expected_kind(input int t);
        if (t_len[t] > FIFO_DEPTH) begin
            return int'(stat_pkg::STAT_OVERFLOW);
        end else if (t_bad[t] != 0) begin
            return int'(stat_pkg::STAT_BAD);
        end
        return int'(stat_pkg::STAT_GOOD);
    endfunction

    function automatic string kind_name(input int kind);
        case (kind)
            0:       return "good";
            1:       return "bad";
            default: return "overflow";
        endcase
    endfunction

    function automatic bit traffic_done();
        for (int c = 0; c < CH_COUNT; c++) begin
            if (cur_pos[c] < ch_list[c].size() || good_q[c].size() > 0) begin
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    task automatic load_descriptors(output bit ok);
        int    fd;
        int    rc;
        int    num;
        int    ch;
        int    len;
        int    bad;
        int    start;
        string line;
        fd = $fopen(INPUT_FILE, "r");
        ok = fd != 0;
        n_tests = 0;
        while (ok && !$feof(fd) && n_tests < MAX_TESTS) begin
            rc = $fgets(line, fd);
            if (rc > 0 && line[0] != "#") begin
                rc = $sscanf(line, "%d %d %d %d %h", num, ch, len, bad, start);
                if (rc == 5 && ch >= 0 && ch < CH_COUNT && len > 0) begin
                    t_num[n_tests]   = num;
                    t_len[n_tests]   = len;
                    t_bad[n_tests]   = bad;
                    t_start[n_tests] = start;
                    ch_list[ch].push_back(n_tests);
                    n_tests++;
                end
            end
        end
        if (ok) begin
            $fclose(fd);
        end
        ok = ok && n_tests > 0;
    endtask

    // Present the current beat of a channel and book its expected outcome
    task automatic set_rx(input int ch);
        int t;
        int idx;
        if (cur_pos[ch] < ch_list[ch].size()) begin
            t = ch_list[ch][cur_pos[ch]];
            if (!started[ch]) begin
                started[ch] = 1'b1;
                idx = ch * stat_pkg::STAT_KINDS + expected_kind(t);
                exp_frames[idx] += 1;
                exp_bytes[idx]  += STAT_COUNT_W'(t_len[t] % 65536);
                if (expected_kind(t) == int'(stat_pkg::STAT_GOOD)) begin
                    good_q[ch].push_back(t);
                end
            end
            rx_beat[ch].data = 8'(t_start[t] + beat_k[ch]);
            rx_beat[ch].last = beat_k[ch] == t_len[t] - 1;
            rx_beat[ch].bad  = rx_beat[ch].last && t_bad[t] != 0;
            rx_valid[ch]     = 1'b1;
        end else begin
            rx_beat[ch]  = '0;
            rx_valid[ch] = 1'b0;
        end
    endtask

    task automatic advance_rx(input int ch);
        int t;
        t = ch_list[ch][cur_pos[ch]];
        beat_k[ch]++;
        if (beat_k[ch] == t_len[t]) begin
            if (expected_kind(t) != int'(stat_pkg::STAT_GOOD)) begin
                dropped++;
                $display("test %0d (ch %0d, %s, %0d bytes): sent, drop expected",
                         t_num[t], ch, kind_name(expected_kind(t)), t_len[t]);
            end
            beat_k[ch]  = 0;
            started[ch] = 1'b0;
            cur_pos[ch]++;
        end
    endtask

    task automatic check_tx(input int ch);
        int         t;
        logic [7:0] exp_data;
        logic       exp_last;
        assert (good_q[ch].size() > 0) else begin
            $display("[FAIL] %t ch %0d: output byte 0x%02h with no frame expected",
                     $time, ch, tx_beat[ch].data);
            errors++;
        end
        if (good_q[ch].size() > 0) begin
            t = good_q[ch][0];
            exp_data = 8'(t_start[t] + out_k[ch]);
            exp_last = out_k[ch] == t_len[t] - 1;
            assert (tx_beat[ch].data == exp_data && tx_beat[ch].last == exp_last
                    && !tx_beat[ch].bad) else begin
                $display(
                    "[FAIL] %t test %0d byte %0d: got %02h last %0b bad %0b, want %02h last %0b",
                    $time, t_num[t], out_k[ch], tx_beat[ch].data, tx_beat[ch].last,
                    tx_beat[ch].bad, exp_data, exp_last);
                errors++;
                test_err[t]++;
            end
            out_k[ch]++;
            if (exp_last) begin
                void'(good_q[ch].pop_front());
                out_k[ch] = 0;
                checked++;
                $display("test %0d (ch %0d, good, %0d bytes): %s", t_num[t], ch, t_len[t],
                         test_err[t] == 0 ? "PASS" : "FAIL");
            end
        end
    endtask

    // Strobe one read, data is sampled one cycle later
    task automatic read_stat(input int idx, output logic [STAT_COUNT_W-1:0] frames,
                             output logic [STAT_COUNT_W-1:0] bytes);
        @(posedge clk);
        #1;
        stat_rd_en   = 1'b1;
        stat_rd_addr = idx[stat_pkg::STAT_ID_W-1:0];
        @(negedge clk);
        assert (!stat_rd_valid) else begin
            $display("Read of statistic %0d saw a valid strobe too early at %t", idx, $time);
            errors++;
        end
        @(posedge clk);
        #1;
        stat_rd_en = 1'b0;
        @(negedge clk);
        assert (stat_rd_valid) else begin
            $display("Read of statistic %0d got no valid strobe at %t", idx, $time);
            errors++;
        end
        frames = stat_rd_frames;
        bytes  = stat_rd_bytes;
    endtask

    initial begin : watchdog
        wait (loaded);
        repeat (limit_cycles) @(posedge clk);
        $display("Timeout: traffic or statistics did not finish within %0d cycles",
                 limit_cycles);
        $display("SOME TESTS FAILED");
        $finish;
    end

    initial begin
        logic [STAT_COUNT_W-1:0] f;
        logic [STAT_COUNT_W-1:0] b;
        int                      total;
        int                      rnd;
        bit                      ok;
        $timeformat(-9, 0, " ns", 0);
        arst_n       = 1'b0;
        rx_valid     = '0;
        tx_ready     = '0;
        stat_rd_en   = 1'b0;
        stat_rd_addr = '0;
        for (int c = 0; c < CH_COUNT; c++) begin
            rx_beat[c]  = '0;
            cur_pos[c]  = 0;
            beat_k[c]   = 0;
            out_k[c]    = 0;
            started[c]  = 1'b0;
            accepted[c] = 1'b0;
        end
        for (int i = 0; i < N_STATS; i++) begin
            exp_frames[i] = '0;
            exp_bytes[i]  = '0;
        end
        for (int i = 0; i < MAX_TESTS; i++) begin
            test_err[i] = 0;
        end
        seed    = SEED;
        errors  = 0;
        checked = 0;
        dropped = 0;
        load_descriptors(ok);
        if (!ok) begin
            $display("Could not read any frame descriptor from %s", INPUT_FILE);
            $display("SOME TESTS FAILED");
            $finish;
        end else begin
            total = 0;
            for (int i = 0; i < n_tests; i++) begin
                total += t_len[i];
            end
            limit_cycles = total * 20 + 2000;
            loaded = 1'b1;

            repeat (8) @(posedge clk);
            #1;
            arst_n = 1'b1;
            @(negedge clk);
            assert (tx_valid == '0) else begin
                $display("[FAIL] %t tx_valid high right after reset", $time);
                errors++;
            end
            // One index past the bank reads as zero too
            for (int i = 0; i <= N_STATS; i++) begin
                read_stat(i, f, b);
                assert (f == '0 && b == '0) else begin
                    $display("[FAIL] %t statistic %0d after reset: %0d frames %0d bytes",
                             $time, i, f, b);
                    errors++;
                end
            end
            $display("reset check: %s", errors == 0 ? "PASS" : "FAIL");

            while (!traffic_done()) begin
                @(posedge clk);
                #1;
                for (int c = 0; c < CH_COUNT; c++) begin
                    if (accepted[c]) begin
                        advance_rx(c);
                    end
                    set_rx(c);
                    rnd = $random(seed);
                    tx_ready[c] = rnd[0];
                end
                @(negedge clk);
                for (int c = 0; c < CH_COUNT; c++) begin
                    accepted[c] = rx_valid[c] && rx_ready[c];
                    if (tx_valid[c] && tx_ready[c]) begin
                        check_tx(c);
                    end
                end
            end

            // Poll until every frame has been counted
            total = 0;
            while (total < n_tests) begin
                total = 0;
                for (int i = 0; i < N_STATS; i++) begin
                    read_stat(i, f, b);
                    total += int'(f);
                end
            end
            total = errors;
            for (int i = 0; i < N_STATS; i++) begin
                read_stat(i, f, b);
                assert (f == exp_frames[i] && b == exp_bytes[i]) else begin
                    $display("[FAIL] %t statistic %0d: %0d frames %0d bytes, expected %0d %0d",
                             $time, i, f, b, exp_frames[i], exp_bytes[i]);
                    errors++;
                end
            end
            // Index outside the bank whose low bits select a live counter
            read_stat(ALIAS_IDX, f, b);
            assert (f == '0 && b == '0) else begin
                $display("[FAIL] %t statistic %0d outside the bank: %0d frames %0d bytes",
                         $time, ALIAS_IDX, f, b);
                errors++;
            end
            assert (tx_valid == '0) else begin
                $display("[FAIL] %t tx_valid still high after traffic drained", $time);
                errors++;
            end
            $display("statistics check: %s", errors == total ? "PASS" : "FAIL");

            $display("Summary: %0d tests, %0d frames checked, %0d frames dropped, %0d errors",
                     n_tests, checked, dropped, errors);
            if (errors == 0) begin
                $display("ALL TESTS PASSED");
            end else begin
                $display("SOME TESTS FAILED");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

/* verif/fpga_core_input.txt */
# test channel length bad start, all decimal except start byte in hex
# byte k of a frame is start + k mod 256, bad applies to the last byte
1 0 16 0 00
2 1 16 0 80
3 0 1 0 3c
4 1 5 1 10
5 0 64 0 a0
6 1 40 0 f0
7 0 30 1 55
8 1 80 0 20
9 1 12 0 c8
10 0 70 1 07
11 0 9 0 e1
12 1 64 0 01
13 0 2 1 99
14 1 1 0 ff
15 0 100 0 30
16 0 33 0 fe
17 1 7 1 42
18 1 25 0 6d

/* all.f */
src/axis_pkg.sv
src/stat_pkg.sv
src/frame_fifo.sv
src/stat_arb_mux.sv
src/stat_counter.sv
src/fpga_core.sv
verif/tb_clk_gen.sv
verif/fpga_core_tb.sv

/* Makefile */
# Verilator build and run of the frame loopback testbench

TOP       ?= fpga_core_tb
SEED      ?= 76
LOG       ?= sim.log
VERILATOR ?= verilator
BUILD_DIR ?= obj_dir

VFLAGS = --binary --timing --assert --timescale 1ns/1ps -j 0 \
         --top-module $(TOP) -GSEED=$(SEED) --Mdir $(BUILD_DIR)

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f all.f
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "SOME TESTS FAILED" $(LOG); then exit 1; fi
	@grep -q "ALL TESTS PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
